//--- source/isa_pkg.sv
package isa_pkg;

  // instruction classes seen by the issue logic
  typedef enum logic [1:0] {
    OP,
    OPIMM,
    LUI,
    NOP
  } itype_t;

  // integer ALU functions
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS  // forwards operand 2, used by lui
  } alu_func_t;

  // rv32i major opcodes
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;

  // funct3 encodings shared by OP and OP-IMM
  localparam logic [2:0] F3_ADDSUB = 3'b000;
  localparam logic [2:0] F3_SLL    = 3'b001;
  localparam logic [2:0] F3_SLT    = 3'b010;
  localparam logic [2:0] F3_SLTU   = 3'b011;
  localparam logic [2:0] F3_XOR    = 3'b100;
  localparam logic [2:0] F3_SR     = 3'b101; // srl or sra, bit 30 decides
  localparam logic [2:0] F3_OR     = 3'b110;
  localparam logic [2:0] F3_AND    = 3'b111;

endpackage

//--- source/core_pkg.sv
package core_pkg;

  // data word on the integer path
  typedef logic [31:0] word_t;

  // architectural register index, x0..x31
  typedef logic [4:0] reg_idx_t;

  // raw fetched instruction word
  typedef logic [31:0] inst_t;

endpackage

//--- source/issue_if.sv
interface issue_if import isa_pkg::*, core_pkg::*; ();

  logic      valid; // one-cycle strobe per issued op
  alu_func_t func;
  word_t     v1;
  word_t     v2;
  reg_idx_t  rd;

  modport issuer (
    output valid, func, v1, v2, rd
  );

  modport station (
    input valid, func, v1, v2, rd
  );

endinterface

//--- source/instruction_queue.sv
module instruction_queue import core_pkg::*; #(
  parameter int IQ_DEPTH = 4
) (
  input  logic  clk_in,
  input  logic  rst_n,
  input  logic  valid_in,
  input  inst_t inst_in,
  input  logic  pop,
  output inst_t inst_out,
  output logic  inst_available,
  output logic  iq_ready
);

  localparam int AW = $clog2(IQ_DEPTH);
  localparam int CW = AW + 1;

  inst_t          mem [IQ_DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [CW-1:0]  count;
  logic           push;

  assign iq_ready       = (count != CW'(IQ_DEPTH));
  assign inst_available = (count != '0);
  assign inst_out       = mem[rd_ptr]; // head word
  assign push           = valid_in && iq_ready;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps itself
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (push) mem[wr_ptr] <= inst_in;
  end

  // count stays within the depth and in step with the pointer distance
  a_no_push_full: assert property (@(posedge clk_in) disable iff (!rst_n)
    (count <= CW'(IQ_DEPTH)) && (count[AW-1:0] == AW'(wr_ptr - rd_ptr)));

  // the issue side only dequeues a word that is there
  a_no_pop_empty: assert property (@(posedge clk_in) disable iff (!rst_n)
    pop |-> inst_available);

endmodule

//--- source/decode.sv
module decode import isa_pkg::*, core_pkg::*; (
  input  inst_t     inst,
  output itype_t    itype,
  output alu_func_t func,
  output word_t     imm,
  output reg_idx_t  rs1,
  output reg_idx_t  rs2,
  output reg_idx_t  rd
);

  logic [2:0] funct3;
  logic       alt;     // bit 30, selects sub and sra

  assign funct3 = inst[14:12];
  assign alt    = inst[30];

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  // shared funct3 map, sub only exists in the register form
  function automatic alu_func_t alu_of(input logic [2:0] f3, input logic a, input logic is_reg);
    case (f3)
      F3_ADDSUB: return (a && is_reg) ? SUB : ADD;
      F3_SLL:    return SLL;
      F3_SLT:    return SLT;
      F3_SLTU:   return SLTU;
      F3_XOR:    return XOR;
      F3_SR:     return a ? SRA : SRL;
      F3_OR:     return OR;
      F3_AND:    return AND;
      default:   return ADD;
    endcase
  endfunction

  always_comb begin
    itype = NOP;
    func  = ADD;
    imm   = {{20{inst[31]}}, inst[31:20]}; // i-type, sign extended
    case (inst[6:0])
      OPC_OP: begin
        itype = OP;
        func  = alu_of(funct3, alt, 1'b1);
      end
      OPC_OPIMM: begin
        itype = OPIMM;
        func  = alu_of(funct3, alt, 1'b0);
        if (funct3 == F3_SLL || funct3 == F3_SR) begin
          imm = {27'b0, inst[24:20]}; // shamt only
        end
      end
      OPC_LUI: begin
        itype = LUI;
        func  = PASS;
        imm   = {inst[31:12], 12'b0};
      end
      default: ;
    endcase
    // writes to x0 have no effect
    if (rd == '0) itype = NOP;
  end

endmodule

//--- source/register_file.sv
module register_file import core_pkg::*; (
  input  logic     clk_in,
  input  logic     rst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rd1,
  output word_t    rd2,
  output logic     busy1,
  output logic     busy2,
  output logic     busy_rd,
  input  reg_idx_t chk_rd,
  input  logic     mark_busy,
  input  reg_idx_t mark_rd,
  input  logic     wb_valid,
  input  reg_idx_t wb_rd,
  input  word_t    wb_data
);

  word_t        regs [1:31]; // x0 is not stored
  logic [31:1]  busy;

  // read with bypass of the writeback on this edge
  function automatic word_t read_port(input reg_idx_t idx);
    if (idx == '0) return '0;
    if (wb_valid && wb_rd == idx) return wb_data;
    return regs[idx];
  endfunction

  // busy unless the pending result lands this cycle
  function automatic logic busy_of(input reg_idx_t idx);
    if (idx == '0) return 1'b0;
    return busy[idx] && !(wb_valid && wb_rd == idx);
  endfunction

  always_comb begin
    rd1     = read_port(rs1);
    rd2     = read_port(rs2);
    busy1   = busy_of(rs1);
    busy2   = busy_of(rs2);
    busy_rd = busy_of(chk_rd);
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else begin
      if (wb_valid && wb_rd != '0) begin
        regs[wb_rd] <= wb_data;
        busy[wb_rd] <= 1'b0;
      end
      // a new owner of the same rd wins over the retiring one
      if (mark_busy && mark_rd != '0) busy[mark_rd] <= 1'b1;
    end
  end

  // every result coming back from the alu has a reservation here
  a_wb_was_busy: assert property (@(posedge clk_in) disable iff (!rst_n)
    (wb_valid && wb_rd != '0) |-> busy[wb_rd]);

endmodule

//--- source/issue_unit.sv
module issue_unit import isa_pkg::*, core_pkg::*; (
  input  logic      inst_available,
  input  itype_t    itype,
  input  alu_func_t func,
  input  word_t     imm,
  input  reg_idx_t  rs1,
  input  reg_idx_t  rs2,
  input  reg_idx_t  rd,
  input  word_t     rd1,
  input  word_t     rd2,
  input  logic      busy1,
  input  logic      busy2,
  input  logic      busy_rd,
  input  logic      rs_free,
  output logic      pop,
  output logic      mark_busy,
  output reg_idx_t  mark_rd,
  issue_if.issuer   iss
);

  logic need1;
  logic need2;
  logic hazard;
  logic go;

  // lui has no register sources, op-imm only rs1
  assign need1  = (itype == OP || itype == OPIMM) && (rs1 != '0);
  assign need2  = (itype == OP) && (rs2 != '0);
  assign hazard = (need1 && busy1) || (need2 && busy2) || busy_rd;

  assign go  = inst_available && (itype != NOP) && !hazard && rs_free;
  assign pop = inst_available && ((itype == NOP) || go); // nops just drop out

  assign mark_busy = go;
  assign mark_rd   = rd;

  assign iss.valid = go;
  assign iss.func  = func;
  assign iss.v1    = (itype == LUI) ? '0 : rd1;
  assign iss.v2    = (itype == OPIMM || itype == LUI) ? imm : rd2;
  assign iss.rd    = rd;

endmodule

//--- source/reservation_station.sv
module reservation_station import isa_pkg::*, core_pkg::*; #(
  parameter int RS_DEPTH = 2
) (
  input  logic      clk_in,
  input  logic      rst_n,
  issue_if.station  iss,
  output logic      rs_free,
  output logic      out_valid,
  output alu_func_t out_func,
  output word_t     out_v1,
  output word_t     out_v2,
  output reg_idx_t  out_rd
);

  localparam int PW = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
  localparam int CW = $clog2(RS_DEPTH + 1);

  alu_func_t      func_q [RS_DEPTH];
  word_t          v1_q   [RS_DEPTH];
  word_t          v2_q   [RS_DEPTH];
  reg_idx_t       rd_q   [RS_DEPTH];
  logic [PW-1:0]  wr_ptr;
  logic [PW-1:0]  rd_ptr;
  logic [CW-1:0]  count;
  logic           take;

  // depth need not be a power of two
  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(RS_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign rs_free = (count != CW'(RS_DEPTH));
  assign take    = (count != '0); // alu always accepts

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= take;
      if (iss.valid) wr_ptr <= next_ptr(wr_ptr);
      if (take) rd_ptr <= next_ptr(rd_ptr);
      case ({iss.valid, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (iss.valid) begin
      func_q[wr_ptr] <= iss.func;
      v1_q[wr_ptr]   <= iss.v1;
      v2_q[wr_ptr]   <= iss.v2;
      rd_q[wr_ptr]   <= iss.rd;
    end
    if (take) begin  // oldest entry goes to the alu
      out_func <= func_q[rd_ptr];
      out_v1   <= v1_q[rd_ptr];
      out_v2   <= v2_q[rd_ptr];
      out_rd   <= rd_q[rd_ptr];
    end
  end

  // the issue side never strobes into a full station
  a_no_write_full: assert property (@(posedge clk_in) disable iff (!rst_n)
    iss.valid |-> (count != CW'(RS_DEPTH)));

endmodule

//--- source/alu.sv
module alu import isa_pkg::*, core_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_n,
  input  logic      valid_in,
  input  alu_func_t func,
  input  word_t     v1,
  input  word_t     v2,
  input  reg_idx_t  rd_in,
  output logic      wb_valid,
  output reg_idx_t  wb_rd,
  output word_t     wb_data
);

  word_t      result;
  logic [4:0] shamt;

  assign shamt = v2[4:0];

  always_comb begin
    case (func)
      ADD:     result = v1 + v2;
      SUB:     result = v1 - v2;
      SLL:     result = v1 << shamt;
      SLT:     result = {31'b0, $signed(v1) < $signed(v2)};
      SLTU:    result = {31'b0, v1 < v2};
      XOR:     result = v1 ^ v2;
      SRL:     result = v1 >> shamt;
      SRA:     result = $signed(v1) >>> shamt; // keeps sign
      OR:      result = v1 | v2;
      AND:     result = v1 & v2;
      PASS:    result = v2;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= valid_in; // one pulse per result
    end
  end

  always_ff @(posedge clk_in) begin
    if (valid_in) begin
      wb_rd   <= rd_in;
      wb_data <= result;
    end
  end

endmodule

//--- source/top_level.sv
module top_level import isa_pkg::*, core_pkg::*; #(
  parameter int IQ_DEPTH = 4,
  parameter int RS_DEPTH = 2
) (
  input  logic     clk_100mhz,
  input  logic     rst_n,
  input  inst_t    instruction,
  input  logic     iq_valid,
  output logic     iq_ready,
  output word_t    data_out,
  output reg_idx_t addr_out,
  output logic     wb_valid
);

  // queue to decode
  inst_t     head_inst;
  logic      inst_available;
  logic      pop;

  // decoded fields
  itype_t    itype;
  alu_func_t func;
  word_t     imm;
  reg_idx_t  rs1, rs2, rd;

  // register block
  word_t     rd1, rd2;
  logic      busy1, busy2, busy_rd;
  logic      mark_busy;
  reg_idx_t  mark_rd;

  // station to alu
  logic      rs_free;
  logic      ex_valid;
  alu_func_t ex_func;
  word_t     ex_v1, ex_v2;
  reg_idx_t  ex_rd;

  issue_if iss ();

  instruction_queue #(.IQ_DEPTH(IQ_DEPTH)) u_iq (
    .clk_in(clk_100mhz), .rst_n(rst_n), .valid_in(iq_valid), .inst_in(instruction),
    .pop(pop), .inst_out(head_inst), .inst_available(inst_available), .iq_ready(iq_ready)
  );

  decode u_decode (
    .inst(head_inst), .itype(itype), .func(func), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd)
  );

  register_file u_regs (
    .clk_in(clk_100mhz), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
    .busy1(busy1), .busy2(busy2), .busy_rd(busy_rd), .chk_rd(rd),
    .mark_busy(mark_busy), .mark_rd(mark_rd),
    .wb_valid(wb_valid), .wb_rd(addr_out), .wb_data(data_out)
  );

  issue_unit u_issue (
    .inst_available(inst_available), .itype(itype), .func(func), .imm(imm),
    .rs1(rs1), .rs2(rs2), .rd(rd), .rd1(rd1), .rd2(rd2),
    .busy1(busy1), .busy2(busy2), .busy_rd(busy_rd), .rs_free(rs_free),
    .pop(pop), .mark_busy(mark_busy), .mark_rd(mark_rd), .iss(iss.issuer)
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH)) u_rs (
    .clk_in(clk_100mhz), .rst_n(rst_n), .iss(iss.station), .rs_free(rs_free),
    .out_valid(ex_valid), .out_func(ex_func), .out_v1(ex_v1), .out_v2(ex_v2), .out_rd(ex_rd)
  );

  alu u_alu (
    .clk_in(clk_100mhz), .rst_n(rst_n), .valid_in(ex_valid), .func(ex_func),
    .v1(ex_v1), .v2(ex_v2), .rd_in(ex_rd),
    .wb_valid(wb_valid), .wb_rd(addr_out), .wb_data(data_out)
  );

endmodule

//--- verif/tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 4;
  localparam int TOTAL_INSTS = 330;
  localparam int LIMIT_CYCLES = TOTAL_INSTS * 20 + 16 + 400;
  localparam logic [6:0] R_OPCODE = 7'b0110011;
  localparam logic [6:0] I_OPCODE = 7'b0010011;
  localparam logic [6:0] U_OPCODE = 7'b0110111;

  logic        clk;
  logic        rst_n;
  logic [31:0] instruction;
  logic        iq_valid;
  logic        iq_ready;
  logic [31:0] data_out;
  logic [4:0]  addr_out;
  logic        wb_valid;

  logic [31:0] model_regs [32];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic [31:0] rng = 32'h3921_85a3;
  logic        saw_full;

  top_level #(.IQ_DEPTH(4), .RS_DEPTH(2)) DUT (
    .clk_100mhz(clk), .rst_n(rst_n), .instruction(instruction), .iq_valid(iq_valid),
    .iq_ready(iq_ready), .data_out(data_out), .addr_out(addr_out), .wb_valid(wb_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, R_OPCODE};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, I_OPCODE};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, U_OPCODE};
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1, "check failed");
    end
  endtask

  // rv32i semantics in program order, one expected result per real write
  task automatic apply_model(input logic [31:0] w);
    logic [6:0]  opc;
    logic [4:0]  dst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic        known;
    opc = w[6:0];
    dst = w[11:7];
    a = model_regs[w[19:15]];
    b = (opc == R_OPCODE) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    known = (opc == R_OPCODE) || (opc == I_OPCODE) || (opc == U_OPCODE);
    r = {w[31:12], 12'h000}; // lui
    if (opc != U_OPCODE) begin
      case (w[14:12])
        3'd0: r = (opc == R_OPCODE && w[30]) ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: r = (a < b) ? 32'd1 : 32'd0;
        3'd4: r = a ^ b;
        3'd5: begin
          if (w[30]) r = $signed(a) >>> b[4:0];
          else r = a >> b[4:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
    end
    if (known && dst != 5'd0) begin
      model_regs[dst] = r;
      exp_rd.push_back(dst);
      exp_data.push_back(r);
    end
  endtask

  // offers one word, returns 1 ns after the edge that took it
  task automatic push(input logic [31:0] w);
    instruction = w;
    iq_valid = 1'b1;
    @(negedge clk);
    while (!iq_ready) begin
      saw_full = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
    apply_model(w);
    #1;
    iq_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic load_reg(input logic [4:0] r, input logic [31:0] value);
    push(enc_u(value[31:12] + {19'b0, value[11]}, r)); // carry for the signed low part
    push(enc_i(value[11:0], r, 3'd0, r));
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_rd.size() != 0 && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    repeat (8) @(negedge clk);
    check_value(exp_rd.size(), 32'd0, "expected writebacks left over");
    check_value({31'b0, DUT.inst_available}, 32'd0, "queue not empty after drain");
    @(posedge clk);
    #1;
  endtask

  task automatic test_reset_and_lui();
    repeat (4) begin
      @(negedge clk);
      check_value({31'b0, iq_ready}, 32'd1, "iq_ready after reset");
      check_value({31'b0, wb_valid}, 32'd0, "wb_valid after reset");
    end
    @(posedge clk);
    #1;
    push(enc_u(20'hABCDE, 5'd1));
    idle(6);
    push(enc_i(12'h123, 5'd1, 3'd0, 5'd1));
    drain();
  endtask

  task automatic test_op_functions();
    logic [31:0] corner [6];
    logic [2:0]  f3s [10];
    corner = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0, 32'h1, 32'h0000_001f};
    f3s = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    for (int p = 0; p < 6; p++) begin
      load_reg(5'd1, (p < 4) ? corner[p] : rand32());
      load_reg(5'd2, (p < 4) ? corner[5 - p] : rand32());
      for (int k = 0; k < 10; k++) begin  // sub and sra are the alternate forms
        push(enc_r((k == 1 || k == 7) ? 7'h20 : 7'h00, 5'd2, 5'd1, f3s[k], 5'(k + 3)));
      end
    end
    drain();
  endtask

  task automatic test_chain_and_independent();
    push(enc_i(12'd1, 5'd0, 3'd0, 5'd4));
    repeat (6) push(enc_r(7'h00, 5'd4, 5'd4, 3'd0, 5'd4)); // each waits on x4
    push(enc_i(12'd3, 5'd0, 3'd0, 5'd7));
    push(enc_i(12'd5, 5'd0, 3'd0, 5'd7)); // same rd again
    for (int r = 10; r < 16; r++) push(enc_i(12'(rand32()), 5'd0, 3'd0, 5'(r)));
    drain();
  endtask

  task automatic test_burst_backpressure();
    saw_full = 1'b0;
    for (int n = 0; n < 16; n++) push(enc_i(12'd1, 5'd8, 3'd0, 5'd8));
    check_value({31'b0, saw_full}, 32'd1, "iq_ready never dropped during burst");
    drain();
  endtask

  task automatic test_nops_and_x0();
    push(32'h0000_2373);                      // csr read into x6
    push(32'h0020_a223);                      // store, rd field 4
    push(32'h0020_8463);                      // branch, rd field 8
    push(enc_i(12'd5, 5'd0, 3'd0, 5'd0));     // addi x0
    push(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    push(enc_u(20'h12345, 5'd0));
    idle(10);
    push(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
    push(enc_i(12'd0, 5'd0, 3'd6, 5'd10));
    drain();
  endtask

  task automatic test_random_mix();
    logic [31:0] r;
    logic [31:0] w;
    logic [6:0]  opc;
    for (int n = 0; n < 200; n++) begin
      r = rand32();
      opc = r[6:0];
      if (opc == R_OPCODE || opc == I_OPCODE || opc == U_OPCODE) opc = 7'b0000011;
      case (rand32() % 8)
        0, 1, 2: w = enc_r({1'b0, (r[14:12] == 3'd0 || r[14:12] == 3'd5) & r[30], 5'b0},
                           {2'b0, r[22:20]}, {2'b0, r[17:15]}, r[14:12], {2'b0, r[9:7]});
        3, 4, 5: w = enc_i(r[31:20], {2'b0, r[17:15]}, r[14:12], {2'b0, r[9:7]});
        6: w = enc_u(r[31:12], {2'b0, r[9:7]});
        default: w = {r[31:7], opc};
      endcase
      push(w);
      if (rand32() % 4 == 0) idle(1); // occasional gap
    end
    drain();
  endtask

  // retired results against the model, in order
  always @(negedge clk) begin
    if (rst_n && wb_valid) begin
      if (exp_rd.size() == 0) begin
        $display("writeback to x%0d at %0t ns with no instruction pending", addr_out, $time);
        $display("Finished with errors");
        $fatal(1, "unexpected writeback");
      end else begin
        check_value({27'b0, addr_out}, {27'b0, exp_rd.pop_front()}, "writeback register");
        check_value(data_out, exp_data.pop_front(), "writeback data");
      end
    end
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Finished with errors");
    $fatal(1, "watchdog");
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    instruction = '0;
    iq_valid = 1'b0;
    saw_full = 1'b0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_and_lui();
    test_op_functions();
    test_chain_and_independent();
    test_burst_backpressure();
    test_nops_and_x0();
    test_random_mix();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- sources.f
source/isa_pkg.sv
source/core_pkg.sv
source/issue_if.sv
source/instruction_queue.sv
source/decode.sv
source/register_file.sv
source/issue_unit.sv
source/reservation_station.sv
source/alu.sv
source/top_level.sv
verif/tb_top.sv

//--- Makefile
TOP := tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
